// ==== rtl/flit_stream_if.sv ====
// Valid/ready flit stream with a transfer when both are high on a clock edge
`timescale 1ns/1ns
`include "noc_settings.svh"

interface flit_stream_if import noc_pkg::*; ();

  logic               valid;
  logic               ready;
  flit_hdr_t          hdr;
  logic [`DATA_W-1:0] data;

  // Producer side
  modport source (
    output valid, hdr, data,
    input  ready
  );

  // Consumer side
  modport sink (
    input  valid, hdr, data,
    output ready
  );

endinterface

// ==== rtl/noc_pkg.sv ====
// Flit and header types for the output port
// Field order fixes the flit bit layout, header in the upper bits
`include "noc_settings.svh"

package noc_pkg;

  // Collective operation carried in the header
  // COLL_NONE marks a plain unicast flit
  typedef enum logic [1:0] {
    COLL_NONE = 2'd0,
    COLL_ADD  = 2'd1,
    COLL_MAX  = 2'd2
  } coll_op_e;

  // Header of 5 bits with the default settings
  typedef struct packed {
    // Set on the final flit of a packet
    logic             last;
    coll_op_e         coll_op;
    // Node that injected the flit
    logic [`ID_W-1:0] src_id;
  } flit_hdr_t;

  // Full flit, header above payload
  typedef struct packed {
    flit_hdr_t          hdr;
    logic [`DATA_W-1:0] data;
  } flit_t;

endpackage

// ==== rtl/noc_settings.svh ====
// Router output port sizing shared by RTL and testbench
// Reduction-capable routes are always the lowest route indices
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// Input routes competing for the output link
`define NUM_ROUTES 4

// Routes 0 .. NUM_RED_ROUTES-1 may carry reduction flits
`define NUM_RED_ROUTES 2

// Flit payload width
`define DATA_W 32

// Node id and source id width
`define ID_W 2

`endif

// ==== rtl/output_arbiter.sv ====
// Splits inputs into unicast and reduction paths and picks the output source
// A pending reduction only wins at a packet boundary of the unicast path
`timescale 1ns/1ns
`include "noc_settings.svh"

module output_arbiter import noc_pkg::*; (
  flit_stream_if.sink   in_s [`NUM_ROUTES],
  flit_stream_if.source uni_s [`NUM_ROUTES],
  flit_stream_if.source red_s [`NUM_RED_ROUTES],
  flit_stream_if.sink   wh_s,
  input  logic          wh_locked_i,
  flit_stream_if.sink   red_out_s,
  flit_stream_if.source out_s
);

  // Routes currently presenting a reduction flit
  logic [`NUM_ROUTES-1:0] red_mask;
  // Reduction result owns the output this cycle
  logic                   sel_red;

  for (genvar i = 0; i < `NUM_ROUTES; i++) begin : g_route
    if (i < `NUM_RED_ROUTES) begin : g_red_capable
      assign red_mask[i] = in_s[i].valid && (in_s[i].hdr.coll_op != COLL_NONE);

      assign red_s[i].valid = red_mask[i];
      assign red_s[i].hdr   = in_s[i].hdr;
      assign red_s[i].data  = in_s[i].data;

      // Ready comes from whichever path the flit was steered to
      assign in_s[i].ready = red_mask[i] ? red_s[i].ready : uni_s[i].ready;
    end else begin : g_uni_only
      assign red_mask[i]   = 1'b0;
      assign in_s[i].ready = uni_s[i].ready;
    end

    // Unicast copy hides reduction flits from the wormhole arbiter
    assign uni_s[i].valid = in_s[i].valid && !red_mask[i];
    assign uni_s[i].hdr   = in_s[i].hdr;
    assign uni_s[i].data  = in_s[i].data;
  end

  // Never break into a packet that is partly sent
  assign sel_red = red_out_s.valid && !wh_locked_i;

  assign out_s.valid = sel_red ? red_out_s.valid : wh_s.valid;
  assign out_s.hdr   = sel_red ? red_out_s.hdr   : wh_s.hdr;
  assign out_s.data  = sel_red ? red_out_s.data  : wh_s.data;

  // Downstream ready reaches only the selected source
  assign red_out_s.ready = sel_red && out_s.ready;
  assign wh_s.ready      = !sel_red && out_s.ready;

endmodule

// ==== rtl/output_port_top.sv ====
// Output port of one router with four input routes and one output link
// Routes 0 and 1 may carry reductions, latency is one cycle without stalls
`timescale 1ns/1ns
`include "noc_settings.svh"

module output_port_top import noc_pkg::*; (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic [`ID_W-1:0]              node_id_i,
  input  logic [`NUM_ROUTES-1:0]        valid_i,
  output logic [`NUM_ROUTES-1:0]        ready_o,
  input  flit_t [`NUM_ROUTES-1:0]       data_i,
  output logic                          valid_o,
  input  logic                          ready_i,
  output flit_t                         data_o
);

  flit_stream_if in_s [`NUM_ROUTES] ();
  flit_stream_if uni_s [`NUM_ROUTES] ();
  flit_stream_if red_s [`NUM_RED_ROUTES] ();
  flit_stream_if wh_s ();
  flit_stream_if red_out_s ();
  flit_stream_if mux_s ();

  logic wh_locked;

  // Flat input ports onto internal streams
  for (genvar i = 0; i < `NUM_ROUTES; i++) begin : g_in
    assign in_s[i].valid = valid_i[i];
    assign in_s[i].hdr   = data_i[i].hdr;
    assign in_s[i].data  = data_i[i].data;
    assign ready_o[i]    = in_s[i].ready;
  end

  // Control block that splits paths and picks the output source
  output_arbiter u_output_arbiter (
    .in_s        (in_s),
    .uni_s       (uni_s),
    .red_s       (red_s),
    .wh_s        (wh_s),
    .wh_locked_i (wh_locked),
    .red_out_s   (red_out_s),
    .out_s       (mux_s)
  );

  wormhole_arbiter u_wormhole_arbiter (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .in_s     (uni_s),
    .out_s    (wh_s),
    .locked_o (wh_locked)
  );

  reduction_unit u_reduction_unit (
    .node_id_i (node_id_i),
    .in_s      (red_s),
    .out_s     (red_out_s)
  );

  output_slice u_output_slice (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .in_s    (mux_s),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .data_o  (data_o)
  );

endmodule

// ==== rtl/output_slice.sv ====
// One-entry register stage on the output link, adds exactly one cycle
// Accepts a new flit in the same cycle the held one drains
`timescale 1ns/1ns

module output_slice import noc_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  flit_stream_if.sink in_s,
  output logic        valid_o,
  input  logic        ready_i,
  output flit_t       data_o
);

  logic  full_q;
  flit_t data_q;

  // Room when empty or when the held flit leaves this cycle
  assign in_s.ready = !full_q || ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (in_s.ready) begin
      full_q <= in_s.valid;
    end
  end

  // Payload register loads only on an input transfer
  always_ff @(posedge clk_i) begin
    if (in_s.valid && in_s.ready) begin
      data_q.hdr  <= in_s.hdr;
      data_q.data <= in_s.data;
    end
  end

  // Output comes straight from the register, stable while stalled
  assign valid_o = full_q;
  assign data_o  = data_q;

endmodule

// ==== rtl/reduction_unit.sv ====
// Combines one reduction flit from every reduction-capable route into a result
// Inputs wait until all carry the same operation, no recovery for mismatches
`timescale 1ns/1ns
`include "noc_settings.svh"

module reduction_unit import noc_pkg::*; (
  input  logic [`ID_W-1:0] node_id_i,
  flit_stream_if.sink      in_s [`NUM_RED_ROUTES],
  flit_stream_if.source    out_s
);

  logic [`NUM_RED_ROUTES-1:0] valid;
  coll_op_e                   op [`NUM_RED_ROUTES];
  logic [`DATA_W-1:0]         data [`NUM_RED_ROUTES];

  logic               same_op;
  logic [`DATA_W-1:0] result;

  for (genvar i = 0; i < `NUM_RED_ROUTES; i++) begin : g_in
    assign valid[i]      = in_s[i].valid;
    assign op[i]         = in_s[i].hdr.coll_op;
    assign data[i]       = in_s[i].data;
    // All inputs are consumed in the same cycle as the result
    assign in_s[i].ready = out_s.valid && out_s.ready;
  end

  // Every route must agree with route 0 on the operation
  always_comb begin
    same_op = 1'b1;
    for (int i = 1; i < `NUM_RED_ROUTES; i++) begin
      if (op[i] != op[0]) begin
        same_op = 1'b0;
      end
    end
  end

  // Sum wraps modulo 2^DATA_W, max compares unsigned
  always_comb begin
    result = '0;
    case (op[0])
      COLL_ADD: begin
        result = data[0];
        for (int i = 1; i < `NUM_RED_ROUTES; i++) begin
          result = result + data[i];
        end
      end
      COLL_MAX: begin
        result = data[0];
        for (int i = 1; i < `NUM_RED_ROUTES; i++) begin
          if (data[i] > result) begin
            result = data[i];
          end
        end
      end
      default: result = '0;
    endcase
  end

  assign out_s.valid       = (&valid) && same_op && (op[0] != COLL_NONE);
  // Result is a single-flit packet sourced by this node
  assign out_s.hdr.last    = 1'b1;
  assign out_s.hdr.coll_op = op[0];
  assign out_s.hdr.src_id  = node_id_i;
  assign out_s.data        = result;

endmodule

// ==== rtl/wormhole_arbiter.sv ====
// Round-robin arbiter that holds its grant until a flit with last set is sent
// Combinational from inputs to outputs, only pointer and lock are registered
`timescale 1ns/1ns
`include "noc_settings.svh"

module wormhole_arbiter import noc_pkg::*; (
  input  logic          clk_i,
  input  logic          reset_i,
  flit_stream_if.sink   in_s [`NUM_ROUTES],
  flit_stream_if.source out_s,
  output logic          locked_o
);

  localparam int PTR_W = $clog2(`NUM_ROUTES);

  // Flattened view of the input streams
  logic [`NUM_ROUTES-1:0] valid;
  flit_t                  flit [`NUM_ROUTES];

  // Search start while unlocked, granted route while locked
  logic [PTR_W-1:0] ptr_q;
  logic             lock_q;

  logic [PTR_W-1:0] pick;
  logic             found;
  logic [PTR_W-1:0] sel;
  logic [PTR_W-1:0] next_ptr;
  logic             xfer;

  for (genvar i = 0; i < `NUM_ROUTES; i++) begin : g_in
    assign valid[i]       = in_s[i].valid;
    assign flit[i].hdr    = in_s[i].hdr;
    assign flit[i].data   = in_s[i].data;
    // Only the granted route with a flit waiting sees downstream ready
    assign in_s[i].ready  = out_s.ready && valid[i] && (sel == PTR_W'(i));
  end

  // First valid route at or after the pointer, wrapping around
  always_comb begin
    int idx;
    pick  = ptr_q;
    found = 1'b0;
    for (int k = 0; k < `NUM_ROUTES; k++) begin
      idx = (int'(ptr_q) + k) % `NUM_ROUTES;
      if (!found && valid[idx]) begin
        pick  = PTR_W'(idx);
        found = 1'b1;
      end
    end
  end

  // Mid-packet the grant stays on the locked route
  assign sel      = lock_q ? ptr_q : pick;
  assign next_ptr = (sel == PTR_W'(`NUM_ROUTES - 1)) ? '0 : sel + 1'b1;

  assign out_s.valid = valid[sel];
  assign out_s.hdr   = flit[sel].hdr;
  assign out_s.data  = flit[sel].data;

  assign xfer = out_s.valid && out_s.ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q  <= '0;
      lock_q <= 1'b0;
    end else if (xfer) begin
      // Lock after a non-last flit, release and move on after the last one
      lock_q <= ~flit[sel].hdr.last;
      ptr_q  <= flit[sel].hdr.last ? next_ptr : sel;
    end
  end

  assign locked_o = lock_q;

endmodule

// ==== src.f ====
+incdir+rtl
rtl/noc_pkg.sv
rtl/flit_stream_if.sv
rtl/wormhole_arbiter.sv
rtl/reduction_unit.sv
rtl/output_arbiter.sv
rtl/output_slice.sv
rtl/output_port_top.sv
tb/output_port_assert.sv
tb/output_port_tb.sv

// ==== tb/output_port_assert.sv ====
// Output link hold rule and reduction lock rule sampled on the rising clock
// Unicast flits must carry COLL_NONE for the lock rule to hold
`timescale 1ns/1ns

module output_port_assert import noc_pkg::*; (
  input logic     clk_i,
  input logic     reset_i,
  input logic     valid_o_i,
  input logic     ready_i,
  input flit_t    data_o_i,
  input logic     wh_locked_i,
  input logic     mux_valid_i,
  input coll_op_e mux_op_i
);

  int fail_count = 0;

  // Stalled output keeps its flit
  a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o_i && !ready_i |=> valid_o_i && $stable(data_o_i))
    else begin
      $error("output flit dropped or changed while stalled");
      fail_count++;
    end

  // Reduction result never reaches the slice inside a partly sent packet
  a_no_red_locked: assert property (@(posedge clk_i) disable iff (reset_i)
    wh_locked_i && mux_valid_i |-> mux_op_i == COLL_NONE)
    else begin
      $error("reduction result offered while wormhole lock set");
      fail_count++;
    end

endmodule

bind output_port_top output_port_assert u_assert (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .valid_o_i   (valid_o),
  .ready_i     (ready_i),
  .data_o_i    (data_o),
  .wh_locked_i (wh_locked),
  .mux_valid_i (mux_s.valid),
  .mux_op_i    (mux_s.hdr.coll_op)
);

// ==== tb/output_port_tb.sv ====
// Random unicast and reduction traffic on four routes with random back-pressure
// Node id is fixed at 3, reductions pair up in order on routes 0 and 1
`timescale 1ns/1ns
`include "noc_settings.svh"

module output_port_tb import noc_pkg::*; ();

  localparam int PACKETS = 300;
  localparam int TIMEOUT = PACKETS * 4 * 8 + 100;
  localparam logic [`ID_W-1:0] NODE_ID = `ID_W'(3);

  logic                          clk_i;
  logic                          reset_i;
  logic [`ID_W-1:0]              node_id_i;
  logic [`NUM_ROUTES-1:0]        valid_i;
  logic [`NUM_ROUTES-1:0]        ready_o;
  flit_t [`NUM_ROUTES-1:0]       data_i;
  logic                          valid_o;
  logic                          ready_i;
  flit_t                         data_o;

  integer seed;
  int     cycles;
  int     packets_seen;
  // Route of a packet still in flight on the output or -1 at a boundary
  int     open_route;

  // Flits still to drive, and flits expected on the output
  flit_t send_q [`NUM_ROUTES][$];
  flit_t exp_q [`NUM_ROUTES][$];
  flit_t red_q [$];

  output_port_top uut (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .node_id_i (node_id_i),
    .valid_i   (valid_i),
    .ready_o   (ready_o),
    .data_i    (data_i),
    .valid_o   (valid_o),
    .ready_i   (ready_i),
    .data_o    (data_o)
  );

  always #20 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR: %s", msg);
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  // Single result flit from the two reduction payloads
  function automatic flit_t reduce_pair(coll_op_e op, logic [`DATA_W-1:0] a,
                                        logic [`DATA_W-1:0] b);
    flit_t f;
    f.hdr.last    = 1'b1;
    f.hdr.coll_op = op;
    f.hdr.src_id  = NODE_ID;
    // ADD wraps at 32 bits, MAX is unsigned
    if (op == COLL_ADD)
      f.data = a + b;
    else
      f.data = (a > b) ? a : b;
    return f;
  endfunction

  // Fills the per-route send queues and the expected queues
  task automatic build_traffic();
    int       route;
    int       len;
    coll_op_e op;
    flit_t    f;
    flit_t    g;
    for (int p = 0; p < PACKETS; p++) begin
      route = {$random(seed)} % `NUM_ROUTES;
      if (route < `NUM_RED_ROUTES && ({$random(seed)} % 4) == 0) begin
        op = ({$random(seed)} % 2) ? COLL_MAX : COLL_ADD;
        f.hdr.last    = 1'b1;
        f.hdr.coll_op = op;
        f.hdr.src_id  = `ID_W'(0);
        f.data        = $random(seed);
        g             = f;
        g.hdr.src_id  = `ID_W'(1);
        g.data        = $random(seed);
        send_q[0].push_back(f);
        send_q[1].push_back(g);
        red_q.push_back(reduce_pair(op, f.data, g.data));
      end else begin
        len = 1 + {$random(seed)} % 4;
        for (int k = 0; k < len; k++) begin
          f.hdr.last    = (k == len - 1);
          f.hdr.coll_op = COLL_NONE;
          f.hdr.src_id  = `ID_W'(route);
          f.data        = $random(seed);
          send_q[route].push_back(f);
          exp_q[route].push_back(f);
        end
      end
    end
  endtask

  // Valid stays up until accepted and gaps fall only between flits
  task automatic drive_inputs(input logic [`NUM_ROUTES-1:0] accepted);
    for (int r = 0; r < `NUM_ROUTES; r++) begin
      if (accepted[r])
        send_q[r].delete(0);
      if (!valid_i[r] || accepted[r]) begin
        if (send_q[r].size() > 0 && ({$random(seed)} % 8) != 0) begin
          valid_i[r] = 1'b1;
          data_i[r]  = send_q[r][0];
        end else begin
          valid_i[r] = 1'b0;
        end
      end
    end
    ready_i = ({$random(seed)} % 4) != 0;
  endtask

  // Output scoreboard with one check per output handshake
  always @(posedge clk_i) begin
    int    route;
    flit_t expected;
    if (!reset_i && valid_o && ready_i) begin
      // Reduction results get their own slot above the route indices
      route = (data_o.hdr.coll_op != COLL_NONE) ? `NUM_ROUTES : int'(data_o.hdr.src_id);
      if (open_route >= 0)
        check_value("packet_order", open_route, route);
      if (route == `NUM_ROUTES) begin
        if (red_q.size() == 0)
          report_error("reduction result seen with no pending reduction");
        else begin
          expected = red_q.pop_front();
          check_value("reduction_result", expected, data_o);
        end
      end else begin
        if (exp_q[route].size() == 0)
          report_error("unicast flit seen with no pending flit on its route");
        else begin
          expected = exp_q[route].pop_front();
          check_value("unicast_flit", expected, data_o);
        end
      end
      open_route = data_o.hdr.last ? -1 : route;
      if (data_o.hdr.last)
        packets_seen++;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
      if (uut.u_assert.fail_count != 0)
        report_error("bound assertion on the output port failed");
    end
    $display("ERROR: output stalled, %0d of %0d packets after %0d cycles",
             packets_seen, PACKETS, cycles);
    $display("Result: FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    logic [`NUM_ROUTES-1:0] accepted;
    int                     leftover;
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    node_id_i    = NODE_ID;
    valid_i      = '0;
    data_i       = '0;
    ready_i      = 1'b0;
    seed         = 91;
    packets_seen = 0;
    open_route   = -1;
    build_traffic();
    repeat (16) @(posedge clk_i);
    #2 reset_i = 1'b0;
    // Idle port after reset
    repeat (3) begin
      @(posedge clk_i);
      check_value("reset_valid_o", 1'b0, valid_o);
      check_value("reset_ready_o", '0, ready_o);
    end
    while (packets_seen < PACKETS) begin
      @(posedge clk_i);
      accepted = valid_i & ready_o;
      #2;
      drive_inputs(accepted);
    end
    leftover = red_q.size();
    for (int r = 0; r < `NUM_ROUTES; r++)
      leftover += exp_q[r].size() + send_q[r].size();
    if (leftover == 0 && uut.u_assert.fail_count == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("ERROR: %0d flits unmatched and %0d assertion failures",
               leftover, uut.u_assert.fail_count);
      $display("Result: FAILED");
      $fatal(1, "run ended with errors");
    end
  end

endmodule
